//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ni
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flit_fifo.sv
/*
 * synchronous flit FIFO, circular buffer with valid/ready on both sides
 */
`default_nettype none

module flit_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic reset,
    flit_if.sink      in_port,
    flit_if.source    out_port
);
    import noc_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    flit_data_t            data_mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] hdr_mem;
    logic [FIFO_DEPTH-1:0] tail_mem;
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_port.ready  = (count != CNT_W'(FIFO_DEPTH));  // not full
    assign out_port.valid = (count != '0);                  // not empty
    assign push = in_port.valid && in_port.ready;
    assign pop  = out_port.valid && out_port.ready;

    assign out_port.data = data_mem[rd_ptr];
    assign out_port.hdr  = hdr_mem[rd_ptr];
    assign out_port.tail = tail_mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_port.data;
            hdr_mem[wr_ptr]  <= in_port.hdr;
            tail_mem[wr_ptr] <= in_port.tail;
        end
    end

    // full: the producer keeps its flit offered, nothing pushed or lost
    a_full_hold: assert property (@(posedge clk) disable iff (reset)
        (in_port.valid && !in_port.ready) |=> (in_port.valid && $stable(in_port.data)));

endmodule

`default_nettype wire

//--- flit_if.sv
/*
 * flit link between an engine and a flit FIFO, valid/ready handshake
 */
`default_nettype none

interface flit_if;
    import noc_pkg::*;

    flit_data_t data;
    logic       hdr;
    logic       tail;
    logic       valid;
    logic       ready;

    modport source (output data, hdr, tail, valid, input ready);
    modport sink   (input data, hdr, tail, valid, output ready);

endinterface

`default_nettype wire

//--- ni_receive_engine.sv
/*
 * depacketizer: pops incoming flits and writes body words to local
 * memory up to the buffer limit, the rest is dropped
 */
`default_nettype none

module ni_receive_engine (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   receive_start_i,
    input  wire ni_reg_pkg::word_addr_t recv_addr_i,
    input  wire ni_reg_pkg::xfer_len_t  recv_max_i,
    output logic                        recv_idle_o,
    output logic                        pkt_waiting_o,
    output logic                        receive_done_o,
    output logic                        wr_en_o,
    output ni_reg_pkg::word_addr_t      wr_addr_o,
    output noc_pkg::flit_data_t         wr_data_o,
    flit_if.sink                        rx
);
    import ni_reg_pkg::*;

    typedef enum logic {IDLE, BODY} recv_state_t;

    recv_state_t state;
    xfer_len_t   word_idx;  // stops counting at the limit
    logic        pop;
    logic        keep;

    assign recv_idle_o   = (state == IDLE);
    assign pkt_waiting_o = rx.valid && rx.hdr;

    // start pops the header, the body then drains at full rate
    assign rx.ready       = (state == BODY) || receive_start_i;
    assign pop            = rx.valid && rx.ready;
    assign receive_done_o = pop && rx.tail;

    assign keep      = (word_idx < recv_max_i);
    assign wr_en_o   = (state == BODY) && rx.valid && keep;
    assign wr_addr_o = recv_addr_i + word_addr_t'(word_idx);
    assign wr_data_o = rx.data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    word_idx <= '0;
                    if (receive_start_i && !rx.tail) begin
                        state <= BODY;  // header only packet ends here
                    end
                end
                BODY: begin
                    if (pop && keep) begin
                        word_idx <= word_idx + 1'b1;
                    end
                    if (pop && rx.tail) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the link delivers whole packets, no header before the tail
    a_no_mid_header: assert property (@(posedge clk) disable iff (reset)
        (state == BODY && rx.valid) |-> !rx.hdr);

endmodule

`default_nettype wire

//--- ni_reg_pkg.sv
/*
 * host side description: bus widths, register map and transfer sizes
 */
`default_nettype none

package ni_reg_pkg;

    localparam int BUS_DW      = 32;
    localparam int REG_AW      = 4;
    localparam int XFER_LEN_W  = 10;
    localparam int WORD_OFFSET = $clog2(BUS_DW / 8);  // byte to word shift

    typedef logic [BUS_DW-1:0]             bus_data_t;
    typedef logic [REG_AW-1:0]             reg_addr_t;
    typedef logic [BUS_DW-WORD_OFFSET-1:0] word_addr_t;
    typedef logic [XFER_LEN_W-1:0]         xfer_len_t;

    localparam reg_addr_t SEND_SIZE_ADDR = 4'd3;
    localparam reg_addr_t SEND_STRT_ADDR = 4'd4;
    localparam reg_addr_t SEND_DEST_ADDR = 4'd5;   // also starts the send
    localparam reg_addr_t RECV_STRT_ADDR = 4'd8;
    localparam reg_addr_t RECV_CTRL_ADDR = 4'd10;  // any write enables receive
    localparam reg_addr_t RECV_MAX_ADDR  = 4'd11;

endpackage

`default_nettype wire

//--- ni_send_engine.sv
/*
 * packetizer: reads words from local memory and pushes a header flit
 * followed by body flits, tail on the last one
 */
`default_nettype none

module ni_send_engine #(
    parameter noc_pkg::coord_x_t NODE_X = 1,
    parameter noc_pkg::coord_y_t NODE_Y = 2
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   send_start_i,
    input  wire ni_reg_pkg::word_addr_t send_addr_i,
    input  wire ni_reg_pkg::xfer_len_t  send_size_i,
    input  wire noc_pkg::coord_x_t      dest_x_i,
    input  wire noc_pkg::coord_y_t      dest_y_i,
    input  wire noc_pkg::pck_class_t    pck_class_i,
    input  wire noc_pkg::flit_data_t    rd_data_i,
    output logic                        send_idle_o,
    output logic                        rd_en_o,
    output ni_reg_pkg::word_addr_t      rd_addr_o,
    flit_if.source                      tx
);
    import noc_pkg::*;
    import ni_reg_pkg::*;

    typedef enum logic [1:0] {IDLE, HEADER, READ, PUSH} send_state_t;

    send_state_t state;
    word_addr_t  cur_addr;
    xfer_len_t   pck_len;
    xfer_len_t   words_left;
    coord_x_t    dst_x;
    coord_y_t    dst_y;
    pck_class_t  dst_class;
    flit_data_t  hdr_word;

    always_comb begin
        hdr_word = '0;
        hdr_word[HDR_DST_X_LSB +: $bits(coord_x_t)]   = dst_x;
        hdr_word[HDR_DST_Y_LSB +: $bits(coord_y_t)]   = dst_y;
        hdr_word[HDR_CLASS_LSB +: $bits(pck_class_t)] = dst_class;
        hdr_word[HDR_SRC_X_LSB +: $bits(coord_x_t)]   = NODE_X;
        hdr_word[HDR_SRC_Y_LSB +: $bits(coord_y_t)]   = NODE_Y;
        hdr_word[HDR_LEN_LSB +: XFER_LEN_W]           = pck_len;
    end

    assign send_idle_o = (state == IDLE);
    assign rd_en_o     = (state == READ);
    assign rd_addr_o   = cur_addr;

    // read data holds until the next read, so a stalled push stays stable
    assign tx.valid = (state == HEADER) || (state == PUSH);
    assign tx.hdr   = (state == HEADER);
    assign tx.data  = (state == HEADER) ? hdr_word : rd_data_i;
    assign tx.tail  = (state == HEADER) ? (pck_len == '0) : (words_left == 10'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (send_start_i) state <= HEADER;
                HEADER:  if (tx.ready) state <= (pck_len == '0) ? IDLE : READ;
                READ:    state <= PUSH;
                PUSH:    if (tx.ready) state <= tx.tail ? IDLE : READ;
                default: state <= IDLE;
            endcase
        end
    end

    // packet fields latched at start, later host writes leave them alone
    always_ff @(posedge clk) begin
        if (state == IDLE && send_start_i) begin
            cur_addr   <= send_addr_i;
            pck_len    <= send_size_i;
            words_left <= send_size_i;
            dst_x      <= dest_x_i;
            dst_y      <= dest_y_i;
            dst_class  <= pck_class_i;
        end else if (state == PUSH && tx.ready) begin
            cur_addr   <= cur_addr + 1'b1;
            words_left <= words_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- ni_slave_regs.sv
/*
 * NI register bank on the Wishbone slave port, starts sends and
 * receives and keeps the receive saved flag
 */
`default_nettype none

module ni_slave_regs #(
    parameter noc_pkg::coord_x_t NODE_X = 1,
    parameter noc_pkg::coord_y_t NODE_Y = 2
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire ni_reg_pkg::bus_data_t  s_dat_i,
    input  wire ni_reg_pkg::reg_addr_t  s_addr_i,
    input  wire logic                   s_stb_i,
    input  wire logic                   s_cyc_i,
    input  wire logic                   s_we_i,
    output logic                        s_ack_o,
    input  wire logic                   send_idle_i,
    input  wire logic                   recv_idle_i,
    input  wire logic                   pkt_waiting_i,
    input  wire logic                   receive_done_i,
    input  wire logic                   rx_saved_clr_i,
    output logic                        send_start_o,
    output ni_reg_pkg::word_addr_t      send_addr_o,
    output ni_reg_pkg::xfer_len_t       send_size_o,
    output noc_pkg::coord_x_t           dest_x_o,
    output noc_pkg::coord_y_t           dest_y_o,
    output noc_pkg::pck_class_t         pck_class_o,
    output logic                        receive_start_o,
    output ni_reg_pkg::word_addr_t      recv_addr_o,
    output ni_reg_pkg::xfer_len_t       recv_max_o,
    output logic                        rx_saved_o
);
    import noc_pkg::*;
    import ni_reg_pkg::*;

    logic wr_req;   // host write strobe
    logic send_wr;
    logic recv_wr;
    logic recv_en;

    assign wr_req  = s_stb_i && s_cyc_i && s_we_i;
    assign send_wr = wr_req && send_idle_i;
    assign recv_wr = wr_req && recv_idle_i;

    assign receive_start_o = recv_idle_i && pkt_waiting_i && recv_en;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o      <= 1'b0;
            send_start_o <= 1'b0;
            recv_en      <= 1'b0;
            rx_saved_o   <= 1'b0;
        end else begin
            s_ack_o      <= wr_req;  // ignored writes get acked too
            send_start_o <= send_wr && (s_addr_i == SEND_DEST_ADDR);
            if (receive_start_o) begin
                recv_en <= 1'b0;  // one packet per enable
            end
            if (rx_saved_clr_i) begin
                rx_saved_o <= 1'b0;
            end
            if (receive_done_i) begin
                rx_saved_o <= 1'b1;
            end
            if (recv_wr && (s_addr_i == RECV_CTRL_ADDR)) begin
                recv_en    <= 1'b1;
                rx_saved_o <= 1'b0;
            end
        end
    end

    // transfer setup, host addresses are in bytes
    always_ff @(posedge clk) begin
        if (send_wr) begin
            case (s_addr_i)
                SEND_SIZE_ADDR: send_size_o <= s_dat_i[XFER_LEN_W-1:0];
                SEND_STRT_ADDR: send_addr_o <= s_dat_i[BUS_DW-1:WORD_OFFSET];
                SEND_DEST_ADDR: begin
                    dest_x_o    <= s_dat_i[HDR_DST_X_LSB +: $bits(coord_x_t)];
                    dest_y_o    <= s_dat_i[HDR_DST_Y_LSB +: $bits(coord_y_t)];
                    pck_class_o <= s_dat_i[HDR_CLASS_LSB +: $bits(pck_class_t)];
                end
                default: ;
            endcase
        end
        if (recv_wr) begin
            case (s_addr_i)
                RECV_STRT_ADDR: recv_addr_o <= s_dat_i[BUS_DW-1:WORD_OFFSET];
                RECV_MAX_ADDR:  recv_max_o  <= s_dat_i[XFER_LEN_W-1:0];
                default: ;
            endcase
        end
    end

    // the latched destination is never this node
    a_no_self_send: assert property (@(posedge clk) disable iff (reset)
        send_start_o |-> !(dest_x_o == NODE_X && dest_y_o == NODE_Y));

    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        s_ack_o |=> !s_ack_o);

endmodule

`default_nettype wire

//--- ni_top.sv
/*
 * network interface top: register bank, send and receive engines and
 * the tx and rx flit FIFOs on plain ports
 */
`default_nettype none

module ni_top #(
    parameter int                FIFO_DEPTH = 4,
    parameter noc_pkg::coord_x_t NODE_X     = 1,
    parameter noc_pkg::coord_y_t NODE_Y     = 2
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire ni_reg_pkg::bus_data_t  s_dat_i,
    input  wire ni_reg_pkg::reg_addr_t  s_addr_i,
    input  wire logic                   s_stb_i,
    input  wire logic                   s_cyc_i,
    input  wire logic                   s_we_i,
    output logic                        s_ack_o,
    output logic                        rd_en_o,
    output ni_reg_pkg::word_addr_t      rd_addr_o,
    input  wire noc_pkg::flit_data_t    rd_data_i,
    output logic                        wr_en_o,
    output ni_reg_pkg::word_addr_t      wr_addr_o,
    output noc_pkg::flit_data_t         wr_data_o,
    output noc_pkg::flit_data_t         flit_o,
    output logic                        flit_hdr_o,
    output logic                        flit_tail_o,
    output logic                        flit_valid_o,
    input  wire logic                   flit_ready_i,
    input  wire noc_pkg::flit_data_t    flit_i,
    input  wire logic                   flit_hdr_i,
    input  wire logic                   flit_tail_i,
    input  wire logic                   flit_valid_i,
    output logic                        flit_ready_o,
    input  wire logic                   rx_saved_clr_i,
    output logic                        rx_saved_o
);
    import noc_pkg::*;
    import ni_reg_pkg::*;

    flit_if tx_flit ();  // send engine to tx FIFO
    flit_if tx_link ();  // tx FIFO to link ports
    flit_if rx_link ();  // link ports to rx FIFO
    flit_if rx_flit ();  // rx FIFO to receive engine

    logic       send_start;
    logic       send_idle;
    word_addr_t send_addr;
    xfer_len_t  send_size;
    coord_x_t   dest_x;
    coord_y_t   dest_y;
    pck_class_t pck_class;
    logic       receive_start;
    logic       recv_idle;
    logic       pkt_waiting;
    logic       receive_done;
    word_addr_t recv_addr;
    xfer_len_t  recv_max;

    assign flit_o          = tx_link.data;
    assign flit_hdr_o      = tx_link.hdr;
    assign flit_tail_o     = tx_link.tail;
    assign flit_valid_o    = tx_link.valid;
    assign tx_link.ready   = flit_ready_i;
    assign rx_link.data    = flit_i;
    assign rx_link.hdr     = flit_hdr_i;
    assign rx_link.tail    = flit_tail_i;
    assign rx_link.valid   = flit_valid_i;
    assign flit_ready_o    = rx_link.ready;

    ni_slave_regs #(.NODE_X(NODE_X), .NODE_Y(NODE_Y)) u_regs (
        .clk, .reset, .s_dat_i, .s_addr_i, .s_stb_i, .s_cyc_i, .s_we_i, .s_ack_o,
        .send_idle_i(send_idle), .recv_idle_i(recv_idle), .pkt_waiting_i(pkt_waiting),
        .receive_done_i(receive_done), .rx_saved_clr_i,
        .send_start_o(send_start), .send_addr_o(send_addr), .send_size_o(send_size),
        .dest_x_o(dest_x), .dest_y_o(dest_y), .pck_class_o(pck_class),
        .receive_start_o(receive_start), .recv_addr_o(recv_addr),
        .recv_max_o(recv_max), .rx_saved_o
    );

    ni_send_engine #(.NODE_X(NODE_X), .NODE_Y(NODE_Y)) u_send (
        .clk, .reset, .send_start_i(send_start), .send_addr_i(send_addr),
        .send_size_i(send_size), .dest_x_i(dest_x), .dest_y_i(dest_y),
        .pck_class_i(pck_class), .rd_data_i, .send_idle_o(send_idle),
        .rd_en_o, .rd_addr_o, .tx(tx_flit.source)
    );

    flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
        .clk, .reset, .in_port(tx_flit.sink), .out_port(tx_link.source)
    );

    flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
        .clk, .reset, .in_port(rx_link.sink), .out_port(rx_flit.source)
    );

    ni_receive_engine u_recv (
        .clk, .reset, .receive_start_i(receive_start), .recv_addr_i(recv_addr),
        .recv_max_i(recv_max), .recv_idle_o(recv_idle), .pkt_waiting_o(pkt_waiting),
        .receive_done_o(receive_done), .wr_en_o, .wr_addr_o, .wr_data_o,
        .rx(rx_flit.sink)
    );

endmodule

`default_nettype wire

//--- noc_pkg.sv
/*
 * network description: mesh geometry, flit payload and the header field
 * layout shared by the register bank and both engines
 */
`default_nettype none

package noc_pkg;

    localparam int MESH_NX     = 4;
    localparam int MESH_NY     = 4;
    localparam int PCK_CLASSES = 4;
    localparam int FLIT_DW     = 32;

    typedef logic [$clog2(MESH_NX)-1:0]     coord_x_t;
    typedef logic [$clog2(MESH_NY)-1:0]     coord_y_t;
    typedef logic [$clog2(PCK_CLASSES)-1:0] pck_class_t;
    typedef logic [FLIT_DW-1:0]             flit_data_t;

    // destination in two nibbles, class above them
    localparam int DST_ADR_HDR_WIDTH = 8;
    localparam int HDR_DST_X_LSB     = 0;
    localparam int HDR_DST_Y_LSB     = DST_ADR_HDR_WIDTH / 2;
    localparam int HDR_CLASS_LSB     = DST_ADR_HDR_WIDTH;
    localparam int HDR_SRC_X_LSB     = DST_ADR_HDR_WIDTH + HDR_DST_Y_LSB;  // 12
    localparam int HDR_SRC_Y_LSB     = 2 * DST_ADR_HDR_WIDTH;              // 16
    localparam int HDR_LEN_LSB       = HDR_SRC_Y_LSB + HDR_DST_Y_LSB;      // 20

endpackage

`default_nettype wire

//--- tb.f
noc_pkg.sv
ni_reg_pkg.sv
flit_if.sv
ni_slave_regs.sv
ni_send_engine.sv
flit_fifo.sv
ni_receive_engine.sv
ni_top.sv
tb_ni.sv

//--- tb_ni.sv
/*
 * NI testbench: random sends under link back-pressure and incoming packets
 * checked against a memory model, link scoreboard and watchdog
 */
`default_nettype none

module tb_ni;
    timeunit 1ns;
    timeprecision 1ps;

    import noc_pkg::*;
    import ni_reg_pkg::*;

    localparam int NODE_X          = 1;
    localparam int NODE_Y          = 2;
    localparam int MAX_LEN         = 12;
    localparam int N_SEND          = 10;
    localparam int N_RECV          = 6;
    localparam int MEM_WORDS       = 1024;
    localparam int WATCHDOG_CYCLES = (N_SEND + N_RECV) * MAX_LEN * 40 + 2000;

    logic       clk = 1'b0;
    logic       reset;
    bus_data_t  s_dat_i;
    reg_addr_t  s_addr_i;
    logic       s_stb_i;
    logic       s_cyc_i;
    logic       s_we_i;
    logic       s_ack_o;
    logic       rd_en_o;
    word_addr_t rd_addr_o;
    flit_data_t rd_data_i = '0;
    logic       wr_en_o;
    word_addr_t wr_addr_o;
    flit_data_t wr_data_o;
    flit_data_t flit_o;
    logic       flit_hdr_o;
    logic       flit_tail_o;
    logic       flit_valid_o;
    logic       flit_ready_i = 1'b1;
    flit_data_t flit_i = '0;
    logic       flit_hdr_i = 1'b0;
    logic       flit_tail_i = 1'b0;
    logic       flit_valid_i = 1'b0;
    logic       flit_ready_o;
    logic       rx_saved_clr_i;
    logic       rx_saved_o;

    flit_data_t  mem [MEM_WORDS];
    logic [33:0] exp_flits [$];         // {hdr, tail, data}
    logic [33:0] link_q [$];            // incoming flits, same layout
    logic [61:0] exp_writes [$];        // {addr, data}
    int          flit_head = 0;
    int          link_head = 0;
    int          write_head = 0;
    logic        link_taken = 1'b0;
    logic        stall_on = 1'b0;
    logic [31:0] rnd_state = 32'he8736fe8;
    logic [31:0] gap_state = 32'he8736fe8;
    int          err_link = 0;
    int          err_mem = 0;
    int          err_host = 0;
    int          err_misc = 0;

    always #5 clk = ~clk;

    ni_top #(.FIFO_DEPTH(4), .NODE_X(coord_x_t'(NODE_X)), .NODE_Y(coord_y_t'(NODE_Y))) UUT (
        .clk, .reset, .s_dat_i, .s_addr_i, .s_stb_i, .s_cyc_i, .s_we_i, .s_ack_o,
        .rd_en_o, .rd_addr_o, .rd_data_i, .wr_en_o, .wr_addr_o, .wr_data_o,
        .flit_o, .flit_hdr_o, .flit_tail_o, .flit_valid_o, .flit_ready_i,
        .flit_i, .flit_hdr_i, .flit_tail_i, .flit_valid_i, .flit_ready_o,
        .rx_saved_clr_i, .rx_saved_o
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_word();
        rnd_state = lcg_next(rnd_state);
        return rnd_state;
    endfunction

    // value in 0 .. bound-1
    function automatic int unsigned pick(input int unsigned bound);
        rnd_state = lcg_next(rnd_state);
        return (rnd_state >> 8) % bound;
    endfunction

    // dest x, dest y, class, src x, src y, length
    function automatic flit_data_t make_header(input int dx, dy, cls, sx, sy, len);
        return flit_data_t'(dx | (dy << 4) | (cls << 8) | (sx << 12) | (sy << 16) | (len << 20));
    endfunction

    // falling edge: ready gaps, read data, incoming link flits
    always @(negedge clk) begin
        gap_state = lcg_next(gap_state);
        flit_ready_i = stall_on ? gap_state[19] : 1'b1;
        if (rd_en_o) begin
            rd_data_i = mem[rd_addr_o[9:0]];  // one cycle read latency
        end
        if (link_taken) begin
            link_head++;
        end
        if (link_head < link_q.size()) begin
            {flit_hdr_i, flit_tail_i, flit_i} = link_q[link_head];
            flit_valid_i = 1'b1;
        end else begin
            flit_valid_i = 1'b0;
        end
    end

    always @(posedge clk) begin
        link_taken <= flit_valid_i && flit_ready_o;
    end

    // outgoing link scoreboard
    always @(posedge clk) begin
        if (!reset && flit_valid_o && flit_ready_i) begin
            if (flit_head >= exp_flits.size()) begin
                err_link++;
                $display("flit %h left on the link while no packet was expected", flit_o);
            end else begin
                if ({flit_hdr_o, flit_tail_o, flit_o} !== exp_flits[flit_head]) begin
                    err_link++;
                    $display("FAIL send_flit expected %h actual %h", exp_flits[flit_head],
                             {flit_hdr_o, flit_tail_o, flit_o});
                end
                flit_head++;
            end
        end
    end

    // memory port checks
    always @(posedge clk) begin
        if (!reset && rd_en_o && 32'(rd_addr_o) >= MEM_WORDS) begin
            err_mem++;
            $display("memory read at %h is outside the memory model", rd_addr_o);
        end
        if (!reset && wr_en_o) begin
            if (write_head >= exp_writes.size()) begin
                err_mem++;
                $display("memory write at %h while no write was expected", wr_addr_o);
            end else begin
                if ({wr_addr_o, wr_data_o} !== exp_writes[write_head]) begin
                    err_mem++;
                    $display("FAIL recv_write expected %h actual %h", exp_writes[write_head],
                             {wr_addr_o, wr_data_o});
                end
                write_head++;
            end
        end
    end

    task automatic host_write(input reg_addr_t addr, input bus_data_t data);
        @(negedge clk);
        if (s_ack_o !== 1'b0) begin
            err_host++;
            $display("FAIL host_ack_width expected 0 actual %b", s_ack_o);
        end
        s_addr_i = addr;
        s_dat_i  = data;
        s_stb_i  = 1'b1;
        s_cyc_i  = 1'b1;
        s_we_i   = 1'b1;
        @(negedge clk);
        if (s_ack_o !== 1'b1) begin
            err_host++;
            $display("FAIL host_ack expected 1 actual %b", s_ack_o);
        end
        s_stb_i = 1'b0;
        s_cyc_i = 1'b0;
        s_we_i  = 1'b0;
    endtask

    task automatic run_send(input logic stall);
        int len;
        int base;
        int dx;
        int dy;
        int cls;
        int i;

        len  = pick(MAX_LEN + 1);
        base = pick(MEM_WORDS / 2 - MAX_LEN);
        dx   = pick(4);
        dy   = pick(4);
        cls  = pick(4);
        if (dx == NODE_X && dy == NODE_Y) begin
            dx = (dx + 1) % 4;  // never the own node
        end
        exp_flits.push_back({1'b1, len == 0, make_header(dx, dy, cls, NODE_X, NODE_Y, len)});
        for (i = 0; i < len; i++) begin
            exp_flits.push_back({1'b0, i == len - 1, mem[base + i]});
        end
        stall_on = stall;
        host_write(SEND_SIZE_ADDR, bus_data_t'(len));
        host_write(SEND_STRT_ADDR, bus_data_t'(base) << 2);
        host_write(SEND_DEST_ADDR, bus_data_t'(dx | (dy << 4) | (cls << 8)));
        // engine busy from here on
        host_write(SEND_SIZE_ADDR, bus_data_t'(pick(MAX_LEN + 1)));
        if (len >= 1) begin
            host_write(SEND_STRT_ADDR, bus_data_t'(pick(MEM_WORDS)) << 2);
        end
        if (len >= 3) begin
            host_write(SEND_DEST_ADDR, bus_data_t'(pick(256)));
        end
        while (flit_head != exp_flits.size()) @(negedge clk);
        stall_on = 1'b0;
    endtask

    task automatic run_receive(input logic enable_first, input logic clear_by_pin);
        int          len;
        int          lim;
        int          base;
        int          cls;
        int          sx;
        int          sy;
        int          i;
        flit_data_t  body [MAX_LEN];
        logic [33:0] pkt [$];

        len  = enable_first ? int'(pick(MAX_LEN + 1)) : 8;  // 9 flits overfill the rx FIFO
        lim  = pick(MAX_LEN + 1);
        base = MEM_WORDS / 2 + pick(MEM_WORDS / 2 - MAX_LEN);
        cls  = pick(4);
        sx   = pick(4);
        sy   = pick(4);
        pkt.push_back({1'b1, len == 0, make_header(NODE_X, NODE_Y, cls, sx, sy, len)});
        for (i = 0; i < len; i++) begin
            body[i] = next_word();
            pkt.push_back({1'b0, i == len - 1, body[i]});
        end
        if (!enable_first) begin
            for (i = 0; i < pkt.size(); i++) begin
                link_q.push_back(pkt[i]);
            end
            while (flit_ready_o) @(negedge clk);
            repeat (20) @(negedge clk);  // no writes allowed while disabled
        end
        for (i = 0; i < len && i < lim; i++) begin
            exp_writes.push_back({word_addr_t'(base + i), body[i]});
        end
        host_write(RECV_STRT_ADDR, bus_data_t'(base) << 2);
        host_write(RECV_MAX_ADDR, bus_data_t'(lim));
        host_write(RECV_CTRL_ADDR, 32'h1);
        if (rx_saved_o !== 1'b0) begin
            err_misc++;
            $display("FAIL rx_saved_ctrl_clear expected 0 actual %b", rx_saved_o);
        end
        if (enable_first) begin
            for (i = 0; i < pkt.size(); i++) begin
                link_q.push_back(pkt[i]);
            end
        end
        while (!rx_saved_o) @(negedge clk);
        if (write_head != exp_writes.size()) begin
            err_misc++;
            $display("receive ended with %0d expected writes missing",
                     exp_writes.size() - write_head);
        end
        if (clear_by_pin) begin
            rx_saved_clr_i = 1'b1;
            @(negedge clk);
            rx_saved_clr_i = 1'b0;
            if (rx_saved_o !== 1'b0) begin
                err_misc++;
                $display("FAIL rx_saved_pin_clear expected 0 actual %b", rx_saved_o);
            end
        end
    endtask

    initial begin
        int a;
        int n;
        int total;

        reset          = 1'b1;
        s_dat_i        = '0;
        s_addr_i       = '0;
        s_stb_i        = 1'b0;
        s_cyc_i        = 1'b0;
        s_we_i         = 1'b0;
        rx_saved_clr_i = 1'b0;
        for (a = 0; a < MEM_WORDS; a++) begin
            mem[a] = next_word();
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (s_ack_o !== 1'b0 || flit_valid_o !== 1'b0 || rd_en_o !== 1'b0 || wr_en_o !== 1'b0
            || rx_saved_o !== 1'b0 || flit_ready_o !== 1'b1) begin
            err_misc++;
            $display("outputs are not in their reset state after reset");
        end
        for (n = 0; n < N_SEND; n++) begin
            run_send(n[0]);  // every other packet under back-pressure
        end
        for (n = 0; n < N_RECV; n++) begin
            run_receive(n != 0, n[0]);
        end
        repeat (5) @(negedge clk);
        if (flit_head != exp_flits.size() || link_head != link_q.size()) begin
            err_misc++;
            $display("flits left over at the end of the run");
        end
        total = err_link + err_mem + err_host + err_misc;
        $display("errors: link %0d, memory %0d, host %0d, other %0d",
                 err_link, err_mem, err_host, err_misc);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
